// File: compile.f
bus_pkg.sv
reg_map_pkg.sv
timestamp_unit.sv
tx_slot_buffer.sv
reg_block.sv
eth_mid_top.sv
tb_eth_mid.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_eth_mid -o tb_eth_mid
out=$(./obj_dir/tb_eth_mid)
echo "$out"
if echo "$out" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
exit 1

// File: tb_eth_mid.sv
module tb_eth_mid;

  localparam int CLK_PERIOD = 40;

  // table operations
  localparam logic [1:0] OP_WRITE = 2'd0;
  localparam logic [1:0] OP_READ  = 2'd1;
  localparam logic [1:0] OP_PULSE = 2'd2;
  localparam logic [1:0] OP_WAIT  = 2'd3;

  // pulse targets
  localparam logic [15:0] PL_INTR  = 16'd0;
  localparam logic [15:0] PL_LTREQ = 16'd1;

  localparam logic [6:0] B_REG  = 7'd1 << reg_map_pkg::BAR_REG;
  localparam logic [6:0] B_SLOT = 7'd1 << reg_map_pkg::BAR_SLOT;
  localparam logic [6:0] B_NONE = 7'd0;

  typedef struct packed {
    logic [1:0]  op;
    logic [6:0]  bar;
    logic [18:0] addr;
    logic [1:0]  sel;
    logic [15:0] data;
    logic [15:0] exp;
    logic        use_model;
  } entry_t;

  logic                clk_125;
  logic                sys_rst;
  bus_pkg::slv_req_t   slv_req;
  logic                rec_intr;
  logic [29:0]         dma_addr_cur;
  logic [13:0]         tx_rd_ptr;
  logic [13:0]         tx_slot_addr;
  logic                local_time_req;
  logic [15:0]         slv_rdata;
  logic                sys_intr;
  bus_pkg::dma_cfg_t   dma_cfg;
  logic [13:0]         tx_wr_ptr;
  logic [15:0]         tx_slot_q;
  logic [47:0]         local_time;

  entry_t      stim [$];
  int          errors;
  int          seed;
  bit          built;
  int unsigned cyc;
  logic        load_exp;

  // reference model state with registers kept as byte-address fields
  logic [31:0] m_status;
  logic [31:0] m_len;
  logic [31:0] m_start;
  logic [31:0] m_wptr;
  logic [31:0] m_cur_snap;
  logic [63:0] m_lt;
  logic [15:0] slot_shadow [int];

  eth_mid_top uut (
    .clk_125          (clk_125),
    .sys_rst          (sys_rst),
    .slv_req_i        (slv_req),
    .rec_intr_i       (rec_intr),
    .dma_addr_cur_i   (dma_addr_cur),
    .tx_rd_ptr_i      (tx_rd_ptr),
    .tx_slot_addr_i   (tx_slot_addr),
    .local_time_req_i (local_time_req),
    .slv_rdata_o      (slv_rdata),
    .sys_intr_o       (sys_intr),
    .dma_cfg_o        (dma_cfg),
    .tx_wr_ptr_o      (tx_wr_ptr),
    .tx_slot_q_o      (tx_slot_q),
    .local_time_o     (local_time)
  );

  initial begin
    clk_125 = 1'b0;
    forever #(CLK_PERIOD / 2) clk_125 = ~clk_125;
  end

  // cycles since reset release track the expected counter value
  always @(posedge clk_125) begin
    if (sys_rst) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // DMA engine address moves every cycle including its high half
  function automatic logic [29:0] dma_cur_at(input int unsigned c);
    return 30'h0abc_1234 + 30'(c) * 30'h0001_0111;
  endfunction

  always @(negedge clk_125) begin
    dma_addr_cur <= dma_cur_at(cyc);
  end

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  function automatic logic [31:0] put_bytes(input logic [31:0] f, input logic hi,
                                            input logic [15:0] d, input logic [1:0] sel);
    int b;
    b = hi ? 16 : 0;
    // bus bits 15:8 carry the lower field byte
    if (sel[1]) f[b +: 8] = d[15:8];
    if (sel[0]) f[b + 8 +: 8] = d[7:0];
    return f;
  endfunction

  function automatic logic [15:0] bus_word(input logic [63:0] f, input int half);
    return {f[16 * half +: 8], f[16 * half + 8 +: 8]};
  endfunction

  function automatic logic [15:0] model_word(input logic [6:0] bar, input logic [18:0] addr);
    logic [63:0] cnt;
    cnt = 64'(cyc);
    if (bar == B_SLOT) begin
      if (addr[14]) return 16'h0000;
      return slot_shadow[int'(addr[13:0])];
    end
    if (bar != B_REG || addr[10:8] != 3'd0) return 16'h0000;
    case (addr[7:0])
      reg_map_pkg::REG_CNT0:         return bus_word(cnt, 0);
      reg_map_pkg::REG_DMA_STATUS:   return bus_word(64'(m_status), 0);
      reg_map_pkg::REG_DMA_LEN_LO:   return bus_word(64'(m_len), 0);
      reg_map_pkg::REG_DMA_LEN_HI:   return bus_word(64'(m_len), 1);
      reg_map_pkg::REG_DMA_START_LO: return bus_word(64'(m_start), 0);
      reg_map_pkg::REG_DMA_START_HI: return bus_word(64'(m_start), 1);
      reg_map_pkg::REG_DMA_CUR_LO:   return bus_word(64'(m_cur_snap), 0);
      reg_map_pkg::REG_DMA_CUR_HI:   return bus_word(64'(m_cur_snap), 1);
      reg_map_pkg::REG_TX_WR_PTR:    return bus_word(64'(m_wptr), 0);
      reg_map_pkg::REG_TX_RD_PTR:    return bus_word(64'(tx_rd_ptr), 0);
      reg_map_pkg::REG_LT0:          return bus_word(m_lt, 0);
      reg_map_pkg::REG_LT1:          return bus_word(m_lt, 1);
      reg_map_pkg::REG_LT2:          return bus_word(m_lt, 2);
      default:                       return 16'h0000;
    endcase
  endfunction

  task automatic model_write(input entry_t e);
    int          w;
    logic [15:0] old;
    if (e.bar == B_SLOT && !e.addr[14]) begin
      w   = int'(e.addr[13:0]);
      old = slot_shadow.exists(w) ? slot_shadow[w] : 16'h0000;
      if (e.sel[1]) old[15:8] = e.data[15:8];
      if (e.sel[0]) old[7:0] = e.data[7:0];
      slot_shadow[w] = old;
    end else if (e.bar == B_REG && e.addr[10:8] == 3'd0) begin
      case (e.addr[7:0])
        reg_map_pkg::REG_DMA_STATUS: begin
          m_status = put_bytes(m_status, 1'b0, e.data, e.sel) & 32'h0000_00ff;
        end
        reg_map_pkg::REG_DMA_LEN_LO, reg_map_pkg::REG_DMA_LEN_HI: begin
          // 20-bit word count above two zero bits
          m_len    = put_bytes(m_len, e.addr[0], e.data, e.sel) & 32'h003f_fffc;
          load_exp = 1'b1;
        end
        reg_map_pkg::REG_DMA_START_LO, reg_map_pkg::REG_DMA_START_HI: begin
          m_start  = put_bytes(m_start, e.addr[0], e.data, e.sel) & 32'hffff_fffc;
          load_exp = 1'b1;
        end
        reg_map_pkg::REG_TX_WR_PTR: begin
          m_wptr = put_bytes(m_wptr, 1'b0, e.data, e.sel) & 32'h0000_3fff;
        end
        default: ;
      endcase
    end
  endtask

  // --------------------------------------------------------------------------
  // checks and bus driving
  // --------------------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // advance one clock and check the outputs that follow the model every cycle
  task automatic tick();
    @(negedge clk_125);
    check_value("dma_cfg_o.load", 64'(dma_cfg.load), 64'(load_exp));
    check_value("sys_intr_o", 64'(sys_intr), 64'(m_status[reg_map_pkg::STATUS_INTR_BIT]));
    check_value("dma_cfg_o.len", 64'(dma_cfg.len), 64'(m_len[21:2]));
    check_value("dma_cfg_o.start", 64'(dma_cfg.start), 64'(m_start[31:2]));
    check_value("tx_wr_ptr_o", 64'(tx_wr_ptr), 64'(m_wptr[13:0]));
    load_exp = 1'b0;
  endtask

  function automatic bus_pkg::slv_req_t make_req(input entry_t e, input logic we);
    bus_pkg::slv_req_t r;
    r       = '0;
    r.bar   = e.bar;
    r.ce    = 1'b1;
    r.we    = we;
    r.addr  = bus_pkg::slv_addr_t'(e.addr);
    r.wdata = e.data;
    r.sel   = e.sel;
    return r;
  endfunction

  task automatic apply_entry(input entry_t e);
    logic [15:0] exp;
    case (e.op)
      OP_WRITE: begin
        slv_req = make_req(e, 1'b1);
        model_write(e);
        tick();
        slv_req.ce = 1'b0;
      end
      OP_READ: begin
        if (e.bar == B_REG && e.addr[10:0] == 11'(reg_map_pkg::REG_DMA_CUR_LO)) begin
          m_cur_snap = {dma_cur_at(cyc), 2'b00};
        end
        exp          = e.use_model ? model_word(e.bar, e.addr) : e.exp;
        slv_req      = make_req(e, 1'b0);
        tx_slot_addr = e.addr[13:0];
        tick();
        slv_req.ce = 1'b0;
        check_value("slv_rdata_o", 64'(slv_rdata), 64'(exp));
        if (e.use_model && e.bar == B_SLOT && !e.addr[14]) begin
          check_value("tx_slot_q_o", 64'(tx_slot_q), 64'(exp));
        end
        if (e.use_model && e.bar == B_REG &&
            e.addr[10:0] == 11'(reg_map_pkg::REG_LT0)) begin
          check_value("local_time_o", 64'(local_time), m_lt);
        end
      end
      OP_PULSE: begin
        if (e.data == PL_LTREQ) begin
          local_time_req = 1'b1;
          // latch two edges after the request edge
          m_lt = (64'(cyc) + 64'd2 - 64'(reg_map_pkg::LT_COMP)) & 64'h0000_ffff_ffff_ffff;
        end else begin
          rec_intr = 1'b1;
          m_status[reg_map_pkg::STATUS_INTR_BIT] = 1'b1;
        end
        tick();
        rec_intr       = 1'b0;
        local_time_req = 1'b0;
      end
      default: begin
        repeat (int'(e.data)) tick();
      end
    endcase
  endtask

  // --------------------------------------------------------------------------
  // stimulus table
  // --------------------------------------------------------------------------
  task automatic add_write(input logic [6:0] bar, input logic [18:0] addr,
                           input logic [1:0] sel, input logic [15:0] data);
    stim.push_back('{OP_WRITE, bar, addr, sel, data, 16'h0, 1'b0});
  endtask

  task automatic add_read(input logic [6:0] bar, input logic [18:0] addr);
    stim.push_back('{OP_READ, bar, addr, 2'b11, 16'h0, 16'h0, 1'b1});
  endtask

  task automatic add_fixed_read(input logic [6:0] bar, input logic [18:0] addr,
                                input logic [15:0] exp);
    stim.push_back('{OP_READ, bar, addr, 2'b11, 16'h0, exp, 1'b0});
  endtask

  task automatic add_pulse(input logic [15:0] which);
    stim.push_back('{OP_PULSE, B_NONE, 19'h0, 2'b00, which, 16'h0, 1'b0});
  endtask

  task automatic add_wait(input logic [15:0] n);
    stim.push_back('{OP_WAIT, B_NONE, 19'h0, 2'b00, n, 16'h0, 1'b0});
  endtask

  task automatic build_table();
    logic [18:0] slot_addr [6];
    // reset values as byte-swapped words
    add_fixed_read(B_REG, 19'(reg_map_pkg::REG_DMA_LEN_LO), 16'h0000);
    add_fixed_read(B_REG, 19'(reg_map_pkg::REG_DMA_LEN_HI), 16'h0100);
    add_fixed_read(B_REG, 19'(reg_map_pkg::REG_DMA_START_LO), 16'h0000);
    add_fixed_read(B_REG, 19'(reg_map_pkg::REG_DMA_START_HI), 16'h0010);
    // byte-select patterns on the DMA and pointer registers
    add_write(B_REG, 19'(reg_map_pkg::REG_DMA_LEN_LO), 2'b11, 16'h1234);
    add_read(B_REG, 19'(reg_map_pkg::REG_DMA_LEN_LO));
    add_write(B_REG, 19'(reg_map_pkg::REG_DMA_LEN_HI), 2'b10, 16'habcd);
    add_read(B_REG, 19'(reg_map_pkg::REG_DMA_LEN_HI));
    add_write(B_REG, 19'(reg_map_pkg::REG_DMA_LEN_HI), 2'b01, 16'h5a3c);
    add_read(B_REG, 19'(reg_map_pkg::REG_DMA_LEN_HI));
    add_write(B_REG, 19'(reg_map_pkg::REG_DMA_START_LO), 2'b01, 16'h1357);
    add_read(B_REG, 19'(reg_map_pkg::REG_DMA_START_LO));
    add_write(B_REG, 19'(reg_map_pkg::REG_DMA_START_HI), 2'b10, 16'h2468);
    add_read(B_REG, 19'(reg_map_pkg::REG_DMA_START_HI));
    add_write(B_REG, 19'(reg_map_pkg::REG_DMA_START_HI), 2'b00, 16'hffff);
    add_read(B_REG, 19'(reg_map_pkg::REG_DMA_START_HI));
    add_read(B_REG, 19'(reg_map_pkg::REG_DMA_START_LO));
    add_write(B_REG, 19'(reg_map_pkg::REG_TX_WR_PTR), 2'b11, 16'ha5c3);
    add_read(B_REG, 19'(reg_map_pkg::REG_TX_WR_PTR));
    add_write(B_REG, 19'(reg_map_pkg::REG_TX_WR_PTR), 2'b10, 16'h0f0f);
    add_read(B_REG, 19'(reg_map_pkg::REG_TX_WR_PTR));
    add_read(B_REG, 19'(reg_map_pkg::REG_TX_RD_PTR));
    add_wait(16'd2);
    // free-running counter
    add_read(B_REG, 19'(reg_map_pkg::REG_CNT0));
    add_wait(16'd3);
    add_read(B_REG, 19'(reg_map_pkg::REG_CNT0));
    // receive interrupt set and clear
    add_read(B_REG, 19'(reg_map_pkg::REG_DMA_STATUS));
    add_pulse(PL_INTR);
    add_wait(16'd1);
    add_read(B_REG, 19'(reg_map_pkg::REG_DMA_STATUS));
    add_write(B_REG, 19'(reg_map_pkg::REG_DMA_STATUS), 2'b11, 16'h0000);
    add_read(B_REG, 19'(reg_map_pkg::REG_DMA_STATUS));
    // slot buffer with random words
    foreach (slot_addr[i]) begin
      slot_addr[i] = {5'b0, 14'($random(seed))};
      add_write(B_SLOT, slot_addr[i], 2'b11, 16'($random(seed)));
    end
    foreach (slot_addr[i]) add_read(B_SLOT, slot_addr[i]);
    add_write(B_SLOT, slot_addr[0], 2'b01, 16'($random(seed)));
    add_read(B_SLOT, slot_addr[0]);
    add_fixed_read(B_SLOT, slot_addr[1] | 19'h0_4000, 16'h0000);
    add_fixed_read(B_REG, 19'h0_0040, 16'h0000);
    add_fixed_read(B_NONE, 19'(reg_map_pkg::REG_CNT0), 16'h0000);
    // transmit timestamp and DMA current address
    add_pulse(PL_LTREQ);
    add_wait(16'd2);
    add_read(B_REG, 19'(reg_map_pkg::REG_LT0));
    add_read(B_REG, 19'(reg_map_pkg::REG_LT1));
    add_read(B_REG, 19'(reg_map_pkg::REG_LT2));
    add_read(B_REG, 19'(reg_map_pkg::REG_DMA_CUR_LO));
    add_wait(16'd2);
    add_read(B_REG, 19'(reg_map_pkg::REG_DMA_CUR_HI));
  endtask

  initial begin
    errors         = 0;
    built          = 1'b0;
    seed           = 32'hf5f4_f11d;
    load_exp       = 1'b0;
    sys_rst        = 1'b1;
    slv_req        = '0;
    rec_intr       = 1'b0;
    local_time_req = 1'b0;
    tx_rd_ptr      = 14'h1234;
    tx_slot_addr   = '0;
    dma_addr_cur   = dma_cur_at(0);
    m_status       = '0;
    m_len          = reg_map_pkg::DMA_LEN_RST;
    m_start        = reg_map_pkg::DMA_START_RST;
    m_wptr         = '0;
    m_cur_snap     = '0;
    m_lt           = '0;
    build_table();
    built = 1'b1;
    repeat (4) @(negedge clk_125);
    sys_rst = 1'b0;
    foreach (stim[i]) apply_entry(stim[i]);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog scaled by the table length
  initial begin
    wait (built);
    #((stim.size() + 20) * CLK_PERIOD * 4);
    $display("watchdog expired before the stimulus table was done");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: eth_mid_top.sv
module eth_mid_top (
  input  logic                        clk_125,
  input  logic                        sys_rst,
  input  bus_pkg::slv_req_t           slv_req_i,
  input  logic                        rec_intr_i,
  input  logic [29:0]                 dma_addr_cur_i,
  input  logic [bus_pkg::SLOT_AW-1:0] tx_rd_ptr_i,
  input  logic [bus_pkg::SLOT_AW-1:0] tx_slot_addr_i,
  input  logic                        local_time_req_i,
  output logic [bus_pkg::DATA_W-1:0]  slv_rdata_o,
  output logic                        sys_intr_o,
  output bus_pkg::dma_cfg_t           dma_cfg_o,
  output logic [bus_pkg::SLOT_AW-1:0] tx_wr_ptr_o,
  output logic [bus_pkg::DATA_W-1:0]  tx_slot_q_o,
  output logic [bus_pkg::LT_W-1:0]    local_time_o
);

  bus_pkg::lt_wr_t              lt_wr;
  logic [bus_pkg::CNT_W-1:0]    global_count;
  logic [bus_pkg::DATA_W-1:0]   slot_rdata;

  // counter and transmit timestamp
  timestamp_unit u_timestamp (
    .clk_125          (clk_125),
    .sys_rst          (sys_rst),
    .local_time_req_i (local_time_req_i),
    .lt_wr_i          (lt_wr),
    .global_count_o   (global_count),
    .local_time_o     (local_time_o)
  );

  // BAR2 slot memory
  tx_slot_buffer u_slot (
    .clk_125        (clk_125),
    .sys_rst        (sys_rst),
    .slv_req_i      (slv_req_i),
    .slot_rdata_o   (slot_rdata),
    .tx_slot_addr_i (tx_slot_addr_i),
    .tx_slot_q_o    (tx_slot_q_o)
  );

  // BAR0 registers and read-data merge
  reg_block u_regs (
    .clk_125        (clk_125),
    .sys_rst        (sys_rst),
    .slv_req_i      (slv_req_i),
    .slot_rdata_i   (slot_rdata),
    .rec_intr_i     (rec_intr_i),
    .dma_addr_cur_i (dma_addr_cur_i),
    .tx_rd_ptr_i    (tx_rd_ptr_i),
    .global_count_i (global_count),
    .local_time_i   (local_time_o),
    .slv_rdata_o    (slv_rdata_o),
    .sys_intr_o     (sys_intr_o),
    .dma_cfg_o      (dma_cfg_o),
    .tx_wr_ptr_o    (tx_wr_ptr_o),
    .lt_wr_o        (lt_wr)
  );

endmodule

// File: reg_block.sv
module reg_block (
  input  logic                        clk_125,
  input  logic                        sys_rst,
  input  bus_pkg::slv_req_t           slv_req_i,
  input  logic [bus_pkg::DATA_W-1:0]  slot_rdata_i,
  input  logic                        rec_intr_i,
  input  logic [29:0]                 dma_addr_cur_i,
  input  logic [bus_pkg::SLOT_AW-1:0] tx_rd_ptr_i,
  input  logic [bus_pkg::CNT_W-1:0]   global_count_i,
  input  logic [bus_pkg::LT_W-1:0]    local_time_i,
  output logic [bus_pkg::DATA_W-1:0]  slv_rdata_o,
  output logic                        sys_intr_o,
  output bus_pkg::dma_cfg_t           dma_cfg_o,
  output logic [bus_pkg::SLOT_AW-1:0] tx_wr_ptr_o,
  output bus_pkg::lt_wr_t             lt_wr_o
);

  logic [reg_map_pkg::REG_IDX_W-1:0] idx;
  logic [reg_map_pkg::REG_IDX_W-1:0] lt_off;
  logic                              reg_wr;
  logic                              reg_rd;
  logic                              dma_wr;
  logic [reg_map_pkg::STATUS_W-1:0]  dma_status;
  bus_pkg::dma_cfg_t                 dma_q;
  logic [bus_pkg::SLOT_AW-1:0]       tx_wr_ptr;
  logic [31:0]                       len_b;
  logic [31:0]                       start_b;
  logic [31:0]                       cur_b;
  logic [31:0]                       old_b;
  logic [31:0]                       new_b;
  logic [15:0]                       rd_word;
  logic [15:0]                       rdata_q;
  logic [15:0]                       cur_hi_q;

  // ------------------------------------------------------------------------
  // decode
  // ------------------------------------------------------------------------
  assign idx    = slv_req_i.addr.reg_view.idx;
  assign reg_wr = slv_req_i.bar[reg_map_pkg::BAR_REG] & slv_req_i.ce &
                  (slv_req_i.addr.reg_view.page == 3'd0) & slv_req_i.we;
  assign reg_rd = slv_req_i.bar[reg_map_pkg::BAR_REG] & slv_req_i.ce &
                  (slv_req_i.addr.reg_view.page == 3'd0) & ~slv_req_i.we;
  assign dma_wr = reg_wr && (idx == reg_map_pkg::REG_DMA_LEN_LO ||
                             idx == reg_map_pkg::REG_DMA_LEN_HI ||
                             idx == reg_map_pkg::REG_DMA_START_LO ||
                             idx == reg_map_pkg::REG_DMA_START_HI);

  // byte views, two zero bits below each word address
  assign len_b   = {10'h0, dma_q.len, 2'b00};
  assign start_b = {dma_q.start, 2'b00};
  assign cur_b   = {dma_addr_cur_i, 2'b00};

  // local-time writes go straight to the timestamp unit
  assign lt_off        = idx - reg_map_pkg::REG_LT0;
  assign lt_wr_o.valid = reg_wr && idx >= reg_map_pkg::REG_LT0 && idx <= reg_map_pkg::REG_LT2;
  assign lt_wr_o.wsel  = lt_off[1:0];
  assign lt_wr_o.data  = slv_req_i.wdata;
  assign lt_wr_o.sel   = slv_req_i.sel;

  // ------------------------------------------------------------------------
  // write merge
  // ------------------------------------------------------------------------
  always_comb begin
    unique case (idx)
      reg_map_pkg::REG_DMA_STATUS:   old_b = {24'h0, dma_status};
      reg_map_pkg::REG_DMA_LEN_LO,
      reg_map_pkg::REG_DMA_LEN_HI:   old_b = len_b;
      reg_map_pkg::REG_DMA_START_LO,
      reg_map_pkg::REG_DMA_START_HI: old_b = start_b;
      reg_map_pkg::REG_TX_WR_PTR:    old_b = {18'h0, tx_wr_ptr};
      default:                       old_b = '0;
    endcase
    // odd index is the upper half of the field
    new_b = old_b;
    if (idx[0]) begin
      new_b[31:16] = reg_map_pkg::merge_word(old_b[31:16], slv_req_i.wdata, slv_req_i.sel);
    end else begin
      new_b[15:0] = reg_map_pkg::merge_word(old_b[15:0], slv_req_i.wdata, slv_req_i.sel);
    end
  end

  // read mux
  always_comb begin
    unique case (idx)
      reg_map_pkg::REG_CNT0:         rd_word = reg_map_pkg::byte_swap(global_count_i[15:0]);
      reg_map_pkg::REG_CNT1:         rd_word = reg_map_pkg::byte_swap(global_count_i[31:16]);
      reg_map_pkg::REG_CNT2:         rd_word = reg_map_pkg::byte_swap(global_count_i[47:32]);
      reg_map_pkg::REG_CNT3:         rd_word = reg_map_pkg::byte_swap(global_count_i[63:48]);
      reg_map_pkg::REG_DMA_STATUS:   rd_word = reg_map_pkg::byte_swap({8'h0, dma_status});
      reg_map_pkg::REG_DMA_LEN_LO:   rd_word = reg_map_pkg::byte_swap(len_b[15:0]);
      reg_map_pkg::REG_DMA_LEN_HI:   rd_word = reg_map_pkg::byte_swap(len_b[31:16]);
      reg_map_pkg::REG_DMA_START_LO: rd_word = reg_map_pkg::byte_swap(start_b[15:0]);
      reg_map_pkg::REG_DMA_START_HI: rd_word = reg_map_pkg::byte_swap(start_b[31:16]);
      reg_map_pkg::REG_DMA_CUR_LO:   rd_word = reg_map_pkg::byte_swap(cur_b[15:0]);
      reg_map_pkg::REG_DMA_CUR_HI:   rd_word = cur_hi_q;
      reg_map_pkg::REG_TX_WR_PTR:    rd_word = reg_map_pkg::byte_swap({2'b00, tx_wr_ptr});
      reg_map_pkg::REG_TX_RD_PTR:    rd_word = reg_map_pkg::byte_swap({2'b00, tx_rd_ptr_i});
      reg_map_pkg::REG_LT0:          rd_word = reg_map_pkg::byte_swap(local_time_i[15:0]);
      reg_map_pkg::REG_LT1:          rd_word = reg_map_pkg::byte_swap(local_time_i[31:16]);
      reg_map_pkg::REG_LT2:          rd_word = reg_map_pkg::byte_swap(local_time_i[47:32]);
      default:                       rd_word = '0;
    endcase
  end

  // ------------------------------------------------------------------------
  // control registers
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      dma_status  <= '0;
      dma_q.len   <= reg_map_pkg::DMA_LEN_RST[21:2];
      dma_q.start <= reg_map_pkg::DMA_START_RST[31:2];
      dma_q.load  <= 1'b0;
      tx_wr_ptr   <= '0;
      rdata_q     <= '0;
    end else begin
      dma_q.load <= dma_wr;
      if (reg_wr) begin
        unique case (idx)
          reg_map_pkg::REG_DMA_STATUS:   dma_status  <= new_b[7:0];
          reg_map_pkg::REG_DMA_LEN_LO,
          reg_map_pkg::REG_DMA_LEN_HI:   dma_q.len   <= new_b[21:2];
          reg_map_pkg::REG_DMA_START_LO,
          reg_map_pkg::REG_DMA_START_HI: dma_q.start <= new_b[31:2];
          reg_map_pkg::REG_TX_WR_PTR:    tx_wr_ptr   <= new_b[13:0];
          default: ;
        endcase
      end
      // a receive pulse wins over a clearing write in the same cycle
      if (rec_intr_i) begin
        dma_status[reg_map_pkg::STATUS_INTR_BIT] <= 1'b1;
      end
      // read data holds until the next access
      if (slv_req_i.ce) begin
        rdata_q <= reg_rd ? rd_word : '0;
      end
    end
  end

  // upper half of the current address, frozen at the low-word read
  always_ff @(posedge clk_125) begin
    if (reg_rd && idx == reg_map_pkg::REG_DMA_CUR_LO) begin
      cur_hi_q <= reg_map_pkg::byte_swap(cur_b[31:16]);
    end
  end

  assign sys_intr_o  = dma_status[reg_map_pkg::STATUS_INTR_BIT];
  assign dma_cfg_o   = dma_q;
  assign tx_wr_ptr_o = tx_wr_ptr;
  assign slv_rdata_o = rdata_q | slot_rdata_i;

endmodule

// File: tx_slot_buffer.sv
module tx_slot_buffer (
  input  logic                        clk_125,
  input  logic                        sys_rst,
  input  bus_pkg::slv_req_t           slv_req_i,
  output logic [bus_pkg::DATA_W-1:0]  slot_rdata_o,
  input  logic [bus_pkg::SLOT_AW-1:0] tx_slot_addr_i,
  output logic [bus_pkg::DATA_W-1:0]  tx_slot_q_o
);

  logic [bus_pkg::DATA_W-1:0]  mem [2**bus_pkg::SLOT_AW];
  logic [bus_pkg::SLOT_AW-1:0] host_addr;
  logic                        host_hit;
  logic [bus_pkg::DATA_W-1:0]  q_a;
  logic                        rd_hit_q;

  assign host_addr = slv_req_i.addr.slot_view.word;
  // slot 0 only, slot_sel set belongs to the dropped second PHY
  assign host_hit  = slv_req_i.bar[reg_map_pkg::BAR_SLOT] & slv_req_i.ce &
                     ~slv_req_i.addr.slot_view.slot_sel;

  // host port A
  always_ff @(posedge clk_125) begin
    if (host_hit) begin
      if (slv_req_i.we) begin
        if (slv_req_i.sel[1]) mem[host_addr][15:8] <= slv_req_i.wdata[15:8];
        if (slv_req_i.sel[0]) mem[host_addr][7:0]  <= slv_req_i.wdata[7:0];
      end
      q_a <= mem[host_addr];
    end
  end

  // transmitter port B, read only
  always_ff @(posedge clk_125) begin
    tx_slot_q_o <= mem[tx_slot_addr_i];
  end

  // held until the next access of any kind
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      rd_hit_q <= 1'b0;
    end else if (slv_req_i.ce) begin
      rd_hit_q <= host_hit & ~slv_req_i.we;
    end
  end

  assign slot_rdata_o = rd_hit_q ? q_a : '0;

endmodule

// File: timestamp_unit.sv
module timestamp_unit (
  input  logic                       clk_125,
  input  logic                       sys_rst,
  input  logic                       local_time_req_i,
  input  bus_pkg::lt_wr_t            lt_wr_i,
  output logic [bus_pkg::CNT_W-1:0]  global_count_o,
  output logic [bus_pkg::LT_W-1:0]   local_time_o
);

  logic req_q;
  logic pending;
  logic ack;
  logic latch_en;

  // one latch per request, and never on top of a host write
  assign latch_en = pending & ~ack & ~lt_wr_i.valid;

  // ------------------------------------------------------------------------
  // global counter and request flags
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      global_count_o <= '0;
      req_q          <= 1'b0;
      pending        <= 1'b0;
      ack            <= 1'b0;
    end else begin
      global_count_o <= global_count_o + 1'b1;
      req_q          <= local_time_req_i;
      ack            <= latch_en;
      if (req_q) begin
        pending <= 1'b1;
      end else if (ack) begin
        pending <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------------
  // local-time register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      local_time_o <= '0;
    end else if (lt_wr_i.valid && lt_wr_i.wsel != 2'd3) begin
      // host fills one 16-bit slice at a time
      local_time_o[16*lt_wr_i.wsel +: 16] <=
        reg_map_pkg::merge_word(local_time_o[16*lt_wr_i.wsel +: 16],
                                lt_wr_i.data, lt_wr_i.sel);
    end else if (latch_en) begin
      // counter before this edge's increment
      local_time_o <= global_count_o[bus_pkg::LT_W-1:0] - reg_map_pkg::LT_COMP;
    end
  end

endmodule

// File: reg_map_pkg.sv
package reg_map_pkg;

  localparam int REG_IDX_W = 8;
  localparam int STATUS_W  = 8;

  // ------------------------------------------------------------------------
  // BAR0 register indices (word address bits 7:0)
  // ------------------------------------------------------------------------
  localparam logic [REG_IDX_W-1:0] REG_CNT0         = 8'h02;
  localparam logic [REG_IDX_W-1:0] REG_CNT1         = 8'h03;
  localparam logic [REG_IDX_W-1:0] REG_CNT2         = 8'h04;
  localparam logic [REG_IDX_W-1:0] REG_CNT3         = 8'h05;
  localparam logic [REG_IDX_W-1:0] REG_DMA_STATUS   = 8'h08;
  localparam logic [REG_IDX_W-1:0] REG_DMA_LEN_LO   = 8'h0a;
  localparam logic [REG_IDX_W-1:0] REG_DMA_LEN_HI   = 8'h0b;
  localparam logic [REG_IDX_W-1:0] REG_DMA_START_LO = 8'h10;
  localparam logic [REG_IDX_W-1:0] REG_DMA_START_HI = 8'h11;
  localparam logic [REG_IDX_W-1:0] REG_DMA_CUR_LO   = 8'h12;
  localparam logic [REG_IDX_W-1:0] REG_DMA_CUR_HI   = 8'h13;
  localparam logic [REG_IDX_W-1:0] REG_TX_WR_PTR    = 8'h18;
  localparam logic [REG_IDX_W-1:0] REG_TX_RD_PTR    = 8'h1a;
  localparam logic [REG_IDX_W-1:0] REG_LT0          = 8'h80;
  localparam logic [REG_IDX_W-1:0] REG_LT1          = 8'h81;
  localparam logic [REG_IDX_W-1:0] REG_LT2          = 8'h82;

  localparam int BAR_REG         = 0;
  localparam int BAR_SLOT        = 2;
  localparam int STATUS_INTR_BIT = 3;

  // reset values in bytes
  localparam logic [31:0] DMA_LEN_RST   = 32'h0001_0000;
  localparam logic [31:0] DMA_START_RST = 32'h1000_0000;

  // counter ticks between the request and the latch
  localparam logic [7:0] LT_COMP = 8'd3;

  // ------------------------------------------------------------------------
  // byte order: field byte 0 sits in bits 15:8 of the bus word
  // ------------------------------------------------------------------------
  function automatic logic [15:0] byte_swap(input logic [15:0] w);
    return {w[7:0], w[15:8]};
  endfunction

  // merge a bus write into one 16-bit field slice, in field order
  function automatic logic [15:0] merge_word(input logic [15:0] old_w,
                                             input logic [15:0] wdata,
                                             input logic [1:0]  sel);
    logic [15:0] m;
    m = old_w;
    if (sel[1]) m[7:0]  = wdata[15:8];
    if (sel[0]) m[15:8] = wdata[7:0];
    return m;
  endfunction

endpackage

// File: bus_pkg.sv
package bus_pkg;

  localparam int SLOT_AW = 14;
  localparam int DATA_W  = 16;
  localparam int CNT_W   = 64;
  localparam int LT_W    = 48;

  // ------------------------------------------------------------------------
  // host bus word address, seen two ways
  // ------------------------------------------------------------------------

  // BAR0 view, byte address bits 19:1
  typedef struct packed {
    logic [7:0] upper;
    logic [2:0] page;
    logic [7:0] idx;
  } reg_addr_t;

  // BAR2 view, slot_sel is bit 15 of the byte address
  typedef struct packed {
    logic [3:0]         upper;
    logic               slot_sel;
    logic [SLOT_AW-1:0] word;
  } slot_addr_t;

  typedef union packed {
    reg_addr_t  reg_view;
    slot_addr_t slot_view;
  } slv_addr_t;

  // one host access, no stall
  typedef struct packed {
    logic [6:0]        bar;
    logic              ce;
    logic              we;
    slv_addr_t         addr;
    logic [DATA_W-1:0] wdata;
    logic [1:0]        sel;
  } slv_req_t;

  // DMA engine settings, all in words
  typedef struct packed {
    logic [19:0] len;
    logic [29:0] start;
    logic        load;
  } dma_cfg_t;

  // host write into the local-time register
  typedef struct packed {
    logic              valid;
    logic [1:0]        wsel;
    logic [DATA_W-1:0] data;
    logic [1:0]        sel;
  } lt_wr_t;

endpackage
